//--- hdl/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regName_t;
    typedef logic [31:0] imm_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes in inst[6:0].
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    // branch funct3.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // load and store width.
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    // alu funct3 shared by OP and OP-IMM.
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } microOp_t;

endpackage

//--- hdl/frontEndPkg.sv
package frontEndPkg;

    import rvIsaPkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [QUEUE_PTR_W-1:0] queuePtr_t;
    typedef logic [QUEUE_CNT_W-1:0] queueCount_t;

    // one fetched word with its pc and static prediction.
    typedef struct packed {
        word_t inst;
        addr_t pc;
        logic  predictTaken;
    } fetchEntry_t;

    // decoded packet handed to rename and rob.
    typedef struct packed {
        logic     valid;
        microOp_t op;
        regName_t rs1;
        regName_t rs2;
        regName_t rd;
        imm_t     imm;
        addr_t    pc;
        logic     predictTaken;
    } issuePacket_t;

endpackage

//--- hdl/instFetch.sv
`timescale 1ns/1ps

module instFetch (
    input  logic                     clk,
    input  logic                     rst,
    output rvIsaPkg::addr_t          imemAddr,
    input  rvIsaPkg::word_t          imemData,
    output logic                     pushValid,
    output frontEndPkg::fetchEntry_t pushEntry,
    input  logic                     pushReady
);
    import rvIsaPkg::*;

    addr_t   pc;
    addr_t   nextPc;
    opcode_t opcode;
    imm_t    jImm;
    imm_t    bImm;
    logic    isJal;
    logic    isBackBranch;
    logic    predictTaken;
    logic    fetchEn;
    logic    pushFire;

    // memory is word indexed.
    assign imemAddr = {2'b00, pc[31:2]};

    assign opcode = imemData[6:0];
    assign jImm = {{12{imemData[31]}}, imemData[19:12], imemData[20],
                   imemData[30:21], 1'b0};
    assign bImm = {{20{imemData[31]}}, imemData[7], imemData[30:25],
                   imemData[11:8], 1'b0};

    // jal always predicted taken, branches only when backward.
    assign isJal        = (opcode == OP_JAL);
    assign isBackBranch = (opcode == OP_BRANCH) && imemData[31];
    assign predictTaken = isJal || isBackBranch;

    always_comb begin
        if (isJal) begin
            nextPc = pc + jImm;
        end else if (isBackBranch) begin
            nextPc = pc + bImm;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    assign pushValid = fetchEn;
    assign pushEntry = '{inst: imemData, pc: pc, predictTaken: predictTaken};
    assign pushFire  = pushValid && pushReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            fetchEn <= 1'b0;
        end else begin
            fetchEn <= 1'b1;
            // hold pc while the queue is full.
            if (pushFire) begin
                pc <= nextPc;
            end
        end
    end

    pcAligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    ) else $error("fetch pc %h not word aligned", pc);

endmodule

//--- hdl/instQueue.sv
`timescale 1ns/1ps

module instQueue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     pushValid,
    input  frontEndPkg::fetchEntry_t pushEntry,
    output logic                     pushReady,
    output logic                     popValid,
    output frontEndPkg::fetchEntry_t popEntry,
    input  logic                     popReady
);
    import frontEndPkg::*;

    fetchEntry_t mem [QUEUE_DEPTH];
    queuePtr_t   wrPtr;
    queuePtr_t   rdPtr;
    queueCount_t count;
    logic        pushFire;
    logic        popFire;

    assign pushReady = (count != queueCount_t'(QUEUE_DEPTH));
    assign popValid  = (count != '0);
    assign popEntry  = mem[rdPtr];
    assign pushFire  = pushValid && pushReady;
    assign popFire   = popValid && popReady;

    always_ff @(posedge clk) begin
        if (pushFire) begin
            mem[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushFire) begin
                wrPtr <= (wrPtr == queuePtr_t'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (popFire) begin
                rdPtr <= (rdPtr == queuePtr_t'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // both at once leaves count alone.
            case ({pushFire, popFire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // a full queue has its write pointer wrapped onto the read pointer.
    fullPtrsMeet: assert property (
        @(posedge clk) disable iff (rst)
        !pushReady |-> wrPtr == rdPtr
    ) else $error("queue full while write and read pointers differ");

    emptyPtrsMeet: assert property (
        @(posedge clk) disable iff (rst)
        !popValid |-> wrPtr == rdPtr
    ) else $error("queue empty while write and read pointers differ");

endmodule

//--- hdl/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      popValid,
    input  frontEndPkg::fetchEntry_t  popEntry,
    output logic                      popReady,
    output frontEndPkg::issuePacket_t issue,
    input  logic                      issueReady
);
    import rvIsaPkg::*;
    import frontEndPkg::*;

    word_t        inst;
    opcode_t      opcode;
    funct3_t      funct3;
    logic         altFunct;
    imm_t         imm;
    microOp_t     op;
    issuePacket_t nextIssue;
    logic         popFire;

    assign inst     = popEntry.inst;
    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    // bit 30 picks sub/sra.
    assign altFunct = inst[30];

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC:         imm = {inst[31:12], 12'b0};
            OP_JAL:                   imm = {{12{inst[31]}}, inst[19:12], inst[20],
                                             inst[30:21], 1'b0};
            OP_BRANCH:                imm = {{20{inst[31]}}, inst[7], inst[30:25],
                                             inst[11:8], 1'b0};
            OP_JALR, OP_IMM, OP_LOAD: imm = {{21{inst[31]}}, inst[30:20]};
            OP_STORE:                 imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:                  imm = '0;
        endcase
    end

    always_comb begin
        op = NOP;
        case (opcode)
            OP_LUI:   op = LUI;
            OP_AUIPC: op = AUIPC;
            OP_JAL:   op = JAL;
            OP_JALR:  op = JALR;
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  op = BEQ;
                    F3_BNE:  op = BNE;
                    F3_BLT:  op = BLT;
                    F3_BGE:  op = BGE;
                    F3_BLTU: op = BLTU;
                    F3_BGEU: op = BGEU;
                    default: op = NOP;
                endcase
            end
            OP_LOAD: begin
                case (funct3)
                    F3_LB:   op = LB;
                    F3_LH:   op = LH;
                    F3_LW:   op = LW;
                    F3_LBU:  op = LBU;
                    F3_LHU:  op = LHU;
                    default: op = NOP;
                endcase
            end
            OP_STORE: begin
                case (funct3)
                    F3_SB:   op = SB;
                    F3_SH:   op = SH;
                    F3_SW:   op = SW;
                    default: op = NOP;
                endcase
            end
            OP_IMM: begin
                // bit 30 is part of the immediate except for shifts.
                case (funct3)
                    F3_ADD:  op = ADDI;
                    F3_SLT:  op = SLTI;
                    F3_SLTU: op = SLTIU;
                    F3_XOR:  op = XORI;
                    F3_OR:   op = ORI;
                    F3_AND:  op = ANDI;
                    F3_SLL:  op = altFunct ? NOP : SLLI;
                    F3_SR:   op = altFunct ? SRAI : SRLI;
                    default: op = NOP;
                endcase
            end
            OP_REG: begin
                case ({altFunct, funct3})
                    {1'b0, F3_ADD}:  op = ADD;
                    {1'b1, F3_ADD}:  op = SUB;
                    {1'b0, F3_SLL}:  op = SLL;
                    {1'b0, F3_SLT}:  op = SLT;
                    {1'b0, F3_SLTU}: op = SLTU;
                    {1'b0, F3_XOR}:  op = XOR;
                    {1'b0, F3_SR}:   op = SRL;
                    {1'b1, F3_SR}:   op = SRA;
                    {1'b0, F3_OR}:   op = OR;
                    {1'b0, F3_AND}:  op = AND;
                    default:         op = NOP;
                endcase
            end
            default: op = NOP;
        endcase
    end

    assign nextIssue = '{valid: 1'b1,
                         op: op,
                         rs1: inst[19:15],
                         rs2: inst[24:20],
                         rd: inst[11:7],
                         imm: imm,
                         pc: popEntry.pc,
                         predictTaken: popEntry.predictTaken};

    // take a new entry once the current packet is gone or leaving.
    assign popReady = !issue.valid || issueReady;
    assign popFire  = popValid && popReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            issue.valid <= 1'b0;
        end else if (popFire) begin
            issue <= nextIssue;
        end else if (issueReady) begin
            issue.valid <= 1'b0;
        end
    end

    issueHeld: assert property (
        @(posedge clk) disable iff (rst)
        issue.valid && !issueReady |=> $stable(issue)
    ) else $error("issue packet changed while stalled");

endmodule

//--- hdl/frontEndTop.sv
`timescale 1ns/1ps

module frontEndTop (
    input  logic                      clk,
    input  logic                      rst,
    output rvIsaPkg::addr_t           imemAddr,
    input  rvIsaPkg::word_t           imemData,
    output frontEndPkg::issuePacket_t issue,
    input  logic                      issueReady
);
    import frontEndPkg::*;

    logic        pushValid;
    logic        pushReady;
    fetchEntry_t pushEntry;
    logic        popValid;
    logic        popReady;
    fetchEntry_t popEntry;

    instFetch fetch (
        .clk       (clk),
        .rst       (rst),
        .imemAddr  (imemAddr),
        .imemData  (imemData),
        .pushValid (pushValid),
        .pushEntry (pushEntry),
        .pushReady (pushReady)
    );

    instQueue queue (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushEntry (pushEntry),
        .pushReady (pushReady),
        .popValid  (popValid),
        .popEntry  (popEntry),
        .popReady  (popReady)
    );

    instDecoder decoder (
        .clk        (clk),
        .rst        (rst),
        .popValid   (popValid),
        .popEntry   (popEntry),
        .popReady   (popReady),
        .issue      (issue),
        .issueReady (issueReady)
    );

endmodule

//--- test/frontEndTb.sv
`timescale 1ns/1ps

module frontEndTb;
    import rvIsaPkg::*;
    import frontEndPkg::*;

    localparam int PACKET_TARGET  = 300;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = PACKET_TARGET * 3 + RESET_CYCLES + 50;

    logic         clk = 1'b0;
    logic         rst;
    logic         issueReady;
    addr_t        imemAddr;
    word_t        imemData;
    issuePacket_t issue;
    word_t        imem [64];
    integer       seed;
    int           errors = 0;
    int           cycles = 0;
    int           acceptCount = 0;
    int           stallCount = 0;
    addr_t        expectPc = '0;
    issuePacket_t heldPkt;
    logic         wasStalled = 1'b0;
    word_t        headWord;
    microOp_t     expOp;
    imm_t         expImm;
    logic         expTaken;
    logic         accepted;

    // decode tables indexed by funct3 or by {bit 30, funct3}.
    microOp_t brTab [8] = '{BEQ, BNE, NOP, NOP, BLT, BGE, BLTU, BGEU};
    microOp_t ldTab [8] = '{LB, LH, LW, NOP, LBU, LHU, NOP, NOP};
    microOp_t stTab [8] = '{SB, SH, SW, NOP, NOP, NOP, NOP, NOP};
    microOp_t immTab [16] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI,
                              ADDI, NOP, SLTI, SLTIU, XORI, SRAI, ORI, ANDI};
    microOp_t regTab [16] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND,
                              SUB, NOP, NOP, NOP, NOP, SRA, NOP, NOP};

    frontEndTop uut (
        .clk        (clk),
        .rst        (rst),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .issue      (issue),
        .issueReady (issueReady)
    );

    always #20 clk = ~clk;

    assign imemData = imem[imemAddr[5:0]];

    function automatic word_t jalWord(int offset, regName_t rd);
        logic [20:0] off;
        off = offset[20:0];
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic word_t branchWord(int offset, funct3_t f3, word_t raw);
        logic [12:0] off;
        off = offset[12:0];
        return {off[12], off[10:5], raw[24:15], f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic microOp_t refOp(word_t w);
        case (w[6:0])
            OP_LUI:    return LUI;
            OP_AUIPC:  return AUIPC;
            OP_JAL:    return JAL;
            OP_JALR:   return JALR;
            OP_BRANCH: return brTab[w[14:12]];
            OP_LOAD:   return ldTab[w[14:12]];
            OP_STORE:  return stTab[w[14:12]];
            OP_IMM:    return immTab[{w[30], w[14:12]}];
            OP_REG:    return regTab[{w[30], w[14:12]}];
            default:   return NOP;
        endcase
    endfunction

    function automatic imm_t refImm(word_t w);
        case (w[6:0])
            OP_LUI, OP_AUIPC:         return {w[31:12], 12'h000};
            OP_JAL:    return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            OP_BRANCH: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            OP_JALR, OP_IMM, OP_LOAD: return 32'($signed(w[31:20]));
            OP_STORE:                 return 32'($signed({w[31:25], w[11:7]}));
            default:                  return '0;
        endcase
    endfunction

    function automatic logic refTaken(word_t w);
        return (w[6:0] == OP_JAL) || (w[6:0] == OP_BRANCH && $signed(refImm(w)) < 0);
    endfunction

    function automatic addr_t refNextPc(word_t w, addr_t pc);
        return refTaken(w) ? pc + refImm(w) : pc + 32'd4;
    endfunction

    task automatic loadProgram();
        word_t   raw;
        funct3_t f3;
        int      i;
        for (i = 0; i < 64; i++) begin
            imem[i] = 32'h0000_0013 + (i << 20);
        end
        raw = $random(seed);
        imem[0] = {raw[31:7], OP_LUI};
        raw = $random(seed);
        imem[1] = {raw[31:7], OP_AUIPC};
        raw = $random(seed);
        imem[2] = {raw[31:15], 3'b000, raw[11:7], OP_JALR};
        imem[3] = jalWord(8, 5'd1);
        // one forward branch per funct3.
        for (i = 0; i < 8; i++) begin
            raw = $random(seed);
            imem[5 + i] = branchWord(4 * (i + 1), funct3_t'(i), raw);
            raw = $random(seed);
            imem[13 + i] = {raw[31:15], funct3_t'(i), raw[11:7], OP_LOAD};
            raw = $random(seed);
            imem[21 + i] = {raw[31:15], funct3_t'(i), raw[11:7], OP_STORE};
        end
        for (i = 0; i < 10; i++) begin
            raw = $random(seed);
            f3 = (i < 8) ? funct3_t'(i) : ((i == 8) ? 3'd1 : 3'd5);
            imem[29 + i] = {raw[31], i >= 8, raw[29:15], f3, raw[11:7], OP_IMM};
        end
        for (i = 0; i < 16; i++) begin
            raw = $random(seed);
            imem[39 + i] = {1'b0, i[3], 5'b00000, raw[24:15], i[2:0], raw[11:7], OP_REG};
        end
        raw = $random(seed);
        imem[55] = {raw[31:7], 7'b1110011};
        // 56 jumps to 58, which branches back to 57, then on to the final loop.
        imem[56] = jalWord(8, 5'd0);
        imem[57] = jalWord(12, 5'd3);
        imem[58] = branchWord(-4, 3'b001, raw);
        imem[60] = jalWord(0, 5'd0);
    endtask

    assign headWord = imem[issue.pc[7:2]];
    assign expOp    = refOp(headWord);
    assign expImm   = refImm(headWord);
    assign expTaken = refTaken(headWord);
    assign accepted = issue.valid && issueReady;

    always @(posedge clk) begin
        cycles     <= cycles + 1;
        heldPkt    <= issue;
        wasStalled <= !rst && issue.valid && !issueReady;
        if (!rst && issue.valid && !issueReady) begin
            stallCount <= stallCount + 1;
        end
        if (!rst && accepted) begin
            acceptCount <= acceptCount + 1;
            expectPc    <= refNextPc(headWord, issue.pc);
        end
    end

    resetQuiet: assert property (@(negedge clk) rst |-> !issue.valid ##1 !issue.valid)
        else begin
            errors++;
            $display("issue valid was raised during reset or in the cycle after it");
        end

    opCheck: assert property (@(posedge clk) disable iff (rst) accepted |-> issue.op == expOp)
        else begin
            errors++;
            $display("FAIL opDecode expected %h actual %h", $sampled(expOp), $sampled(issue.op));
        end

    immCheck: assert property (@(posedge clk) disable iff (rst) accepted |-> issue.imm == expImm)
        else begin
            errors++;
            $display("FAIL immediate expected %h actual %h", $sampled(expImm), $sampled(issue.imm));
        end

    regCheck: assert property (@(posedge clk) disable iff (rst) accepted |->
        {issue.rs1, issue.rs2, issue.rd} == {headWord[19:15], headWord[24:20], headWord[11:7]})
        else begin
            errors++;
            $display("FAIL regNames expected %h actual %h",
                     $sampled({headWord[19:15], headWord[24:20], headWord[11:7]}),
                     $sampled({issue.rs1, issue.rs2, issue.rd}));
        end

    pcCheck: assert property (@(posedge clk) disable iff (rst) accepted |-> issue.pc == expectPc)
        else begin
            errors++;
            $display("FAIL pcSequence expected %h actual %h", $sampled(expectPc), $sampled(issue.pc));
        end

    takenCheck: assert property (@(posedge clk) disable iff (rst)
        accepted |-> issue.predictTaken == expTaken)
        else begin
            errors++;
            $display("FAIL predictTaken expected %b actual %b",
                     $sampled(expTaken), $sampled(issue.predictTaken));
        end

    holdCheck: assert property (@(posedge clk) disable iff (rst) wasStalled |-> issue == heldPkt)
        else begin
            errors++;
            $display("FAIL stallHold expected %h actual %h", $sampled(heldPkt), $sampled(issue));
        end

    initial begin
        seed       = 32'he11c;
        rst        = 1'b1;
        issueReady = 1'b0;
        loadProgram();
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // ready is low about 40% of the time.
        while (acceptCount < PACKET_TARGET && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            issueReady = ({$random(seed)} % 10) >= 4;
        end
        if (acceptCount < PACKET_TARGET) begin
            errors++;
            $display("timeout after %0d cycles with only %0d of %0d packets accepted",
                     cycles, acceptCount, PACKET_TARGET);
        end
        $display("accepted %0d packets, %0d stall cycles, %0d errors",
                 acceptCount, stallCount, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/rvIsaPkg.sv
hdl/frontEndPkg.sv
hdl/instFetch.sv
hdl/instQueue.sv
hdl/instDecoder.sv
hdl/frontEndTop.sv
test/frontEndTb.sv
